/* vdp_pkg.sv */
// register number enum, video timing constants and memory sizes
`default_nettype none

package vdp_pkg;

    // counter widths first, the timing constants are sized by them
    localparam int H_CW = 5;                    // horizontal count bits
    localparam int V_CW = 4;                    // vertical count bits

    // horizontal timing in pixel clocks
    localparam logic [H_CW-1:0] H_VISIBLE    = 5'd16;   // visible pixels
    localparam logic [H_CW-1:0] H_SYNC_START = 5'd18;   // hsync on
    localparam logic [H_CW-1:0] H_SYNC_END   = 5'd20;   // hsync off (exclusive)
    localparam logic [H_CW-1:0] H_TOTAL      = 5'd24;   // clocks per line

    // vertical timing in lines
    localparam logic [V_CW-1:0] V_VISIBLE    = 4'd8;    // visible lines
    localparam logic [V_CW-1:0] V_SYNC_LINE  = 4'd9;    // vsync high whole line
    localparam logic [V_CW-1:0] V_TOTAL      = 4'd12;   // lines per frame

    localparam int WORDS_PER_LINE = 4;          // 4 pixels per vram word
    localparam int VRAM_AW        = 8;          // 256 words
    localparam int PAL_AW         = 4;          // 16 palette entries
    localparam int INTR_BITS      = 4;          // bit 0 vblank, 3:1 software

    // cpu visible register numbers
    typedef enum logic [3:0] {
        REG_VRAM_ADDR   = 4'd0,                 // vram word address
        REG_VRAM_DATA   = 4'd1,                 // vram data, auto increment
        REG_PAL_ADDR    = 4'd2,                 // palette index
        REG_PAL_DATA    = 4'd3,                 // palette color, auto increment
        REG_INTR_MASK   = 4'd4,                 // interrupt enable mask
        REG_INTR_STATUS = 4'd5                  // pending status / clear / signal
    } reg_num_e;

endpackage

`default_nettype wire

/* vram.sv */
// single port 256x16 video ram, read-first with registered read
`default_nettype none
`timescale 1ns/1ps

module vram (
    input  wire logic                          clk,
    input  wire logic                          sel_i,
    input  wire logic                          wr_i,
    input  wire logic [vdp_pkg::VRAM_AW-1:0]   addr_i,
    input  wire logic [15:0]                   wdata_i,
    output logic      [15:0]                   rdata_o
);
    import vdp_pkg::*;

    logic [15:0] mem [1 << VRAM_AW];

    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (wr_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];             // old data on a write
        end
    end

endmodule

`default_nettype wire

/* video_timing.sv */
// beam counters with registered sync, display enable and vblank strobe
`default_nettype none
`timescale 1ns/1ps

module video_timing (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    output logic      [vdp_pkg::H_CW-1:0]   h_count_o,
    output logic      [vdp_pkg::V_CW-1:0]   v_count_o,
    output logic                            de_o,
    output logic                            hsync_o,
    output logic                            vsync_o,
    output logic                            vblank_o
);
    import vdp_pkg::*;

    logic [H_CW-1:0] h_cnt;
    logic [V_CW-1:0] v_cnt;

    // free running raster counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_TOTAL - 1'b1) begin
            h_cnt <= '0;
            if (v_cnt == V_TOTAL - 1'b1) begin
                v_cnt <= '0;                    // new frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // stage 1 register, position and decode stay aligned
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o <= '0;
            v_count_o <= '0;
            de_o      <= 1'b0;
            hsync_o   <= 1'b0;
            vsync_o   <= 1'b0;
            vblank_o  <= 1'b0;
        end else begin
            h_count_o <= h_cnt;
            v_count_o <= v_cnt;
            de_o      <= (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
            hsync_o   <= (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
            vsync_o   <= (v_cnt == V_SYNC_LINE);
            vblank_o  <= (h_cnt == '0) && (v_cnt == V_VISIBLE);    // first clock of blank
        end
    end

endmodule

`default_nettype wire

/* pixel_fetch.sv */
// vram slot arbiter, word fetch, nibble select and two stage sync delay
`default_nettype none
`timescale 1ns/1ps

module pixel_fetch (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    input  wire logic [vdp_pkg::H_CW-1:0]      h_count_i,
    input  wire logic [vdp_pkg::V_CW-1:0]      v_count_i,
    input  wire logic                          de_i,
    input  wire logic                          hsync_i,
    input  wire logic                          vsync_i,
    input  wire logic                          cpu_req_i,
    input  wire logic                          cpu_wr_i,
    input  wire logic [vdp_pkg::VRAM_AW-1:0]   cpu_addr_i,
    input  wire logic [15:0]                   cpu_wdata_i,
    output logic                               cpu_done_o,
    output logic      [15:0]                   cpu_rdata_o,
    output logic      [vdp_pkg::PAL_AW-1:0]    color_index_o,
    output logic                               de_o,
    output logic                               hsync_o,
    output logic                               vsync_o
);
    import vdp_pkg::*;

    logic                vid_slot, cpu_grant;
    logic                vid_load_q;            // fetched word valid this clock
    logic                vram_sel, vram_wr;
    logic [VRAM_AW-1:0]  vid_addr, vram_addr;
    logic [15:0]         vram_rdata, vid_word_q, cur_word;
    logic [1:0]          x_q;
    logic                de_q, hsync_q, vsync_q;

    // video owns every 4th visible clock
    assign vid_slot  = de_i && (h_count_i[1:0] == 2'd0);
    // no grant while previous cpu access is still completing
    assign cpu_grant = cpu_req_i && !vid_slot && !cpu_done_o;
    assign vid_addr  = VRAM_AW'(v_count_i) * VRAM_AW'(WORDS_PER_LINE)
                     + VRAM_AW'(h_count_i[H_CW-1:2]);

    assign vram_sel  = vid_slot || cpu_grant;
    assign vram_wr   = cpu_grant && cpu_wr_i;   // video never writes
    assign vram_addr = vid_slot ? vid_addr : cpu_addr_i;

    vram vram_i (
        .clk     (clk),
        .sel_i   (vram_sel),
        .wr_i    (vram_wr),
        .addr_i  (vram_addr),
        .wdata_i (cpu_wdata_i),
        .rdata_o (vram_rdata)
    );

    assign cpu_rdata_o = vram_rdata;
    assign cur_word    = vid_load_q ? vram_rdata : vid_word_q;

    always_ff @(posedge clk) begin
        if (vid_load_q) begin
            vid_word_q <= vram_rdata;           // hold for pixels 1..3
        end
        x_q           <= h_count_i[1:0];
        color_index_o <= cur_word[{~x_q, 2'b00} +: PAL_AW];    // leftmost in top nibble
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cpu_done_o <= 1'b0;
            vid_load_q <= 1'b0;
            de_q       <= 1'b0;
            hsync_q    <= 1'b0;
            vsync_q    <= 1'b0;
            de_o       <= 1'b0;
            hsync_o    <= 1'b0;
            vsync_o    <= 1'b0;
        end else begin
            cpu_done_o <= cpu_grant;            // data valid one clock after select
            vid_load_q <= vid_slot;
            de_q       <= de_i;                 // stage 2
            hsync_q    <= hsync_i;
            vsync_q    <= vsync_i;
            de_o       <= de_q;                 // stage 3
            hsync_o    <= hsync_q;
            vsync_o    <= vsync_q;
        end
    end

endmodule

`default_nettype wire

/* color_out.sv */
// palette memory, color lookup and blanked rgb output register
`default_nettype none
`timescale 1ns/1ps

module color_out (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    input  wire logic [vdp_pkg::PAL_AW-1:0]   color_index_i,
    input  wire logic                         de_i,
    input  wire logic                         hsync_i,
    input  wire logic                         vsync_i,
    input  wire logic                         pal_wr_i,
    input  wire logic [vdp_pkg::PAL_AW-1:0]   pal_addr_i,
    input  wire logic [11:0]                  pal_wdata_i,
    output logic      [3:0]                   red_o,
    output logic      [3:0]                   green_o,
    output logic      [3:0]                   blue_o,
    output logic                              hsync_o,
    output logic                              vsync_o,
    output logic                              dv_de_o
);
    import vdp_pkg::*;

    logic [11:0] pal_mem [1 << PAL_AW];
    logic [11:0] pal_q;                         // looked up color
    logic        de_q, hsync_q, vsync_q;

    // stage 4, palette write port and registered lookup
    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal_mem[pal_addr_i] <= pal_wdata_i;
        end
        pal_q <= pal_mem[color_index_i];
    end

    // stage 5 output register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_q    <= 1'b0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            dv_de_o <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            red_o   <= 4'h0;
            green_o <= 4'h0;
            blue_o  <= 4'h0;
        end else begin
            de_q    <= de_i;                    // match lookup delay
            hsync_q <= hsync_i;
            vsync_q <= vsync_i;
            dv_de_o <= de_q;
            hsync_o <= hsync_q;
            vsync_o <= vsync_q;
            red_o   <= de_q ? pal_q[11:8] : 4'h0;   // black in blanking
            green_o <= de_q ? pal_q[7:4]  : 4'h0;
            blue_o  <= de_q ? pal_q[3:0]  : 4'h0;
        end
    end

endmodule

`default_nettype wire

/* bus_regs.sv */
// cpu register file with vram request queue, palette port and interrupt unit
`default_nettype none
`timescale 1ns/1ps

module bus_regs (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    input  wire logic                          bus_cs_n_i,     // strobe, active low
    input  wire logic                          bus_rd_nwr_i,   // 1 read, 0 write
    input  wire logic [3:0]                    bus_reg_num_i,
    input  wire logic                          bus_bytesel_i,  // 0 high byte, 1 low byte
    input  wire logic [7:0]                    bus_data_i,
    output logic      [7:0]                    bus_data_o,
    output logic                               cpu_req_o,      // held until done
    output logic                               cpu_wr_o,
    output logic      [vdp_pkg::VRAM_AW-1:0]   cpu_addr_o,
    output logic      [15:0]                   cpu_wdata_o,
    input  wire logic                          cpu_done_i,
    input  wire logic [15:0]                   cpu_rdata_i,
    output logic                               pal_wr_o,
    output logic      [vdp_pkg::PAL_AW-1:0]    pal_addr_o,
    output logic      [11:0]                   pal_wdata_o,
    input  wire logic                          vblank_i,
    output logic                               bus_intr_o
);
    import vdp_pkg::*;

    reg_num_e               reg_sel;
    logic                   wr_stb, rd_stb, word_wr;
    logic [7:0]             hi_byte;            // even byte latch
    logic [15:0]            wr_word, rd_word;
    logic [15:0]            rb_latch;           // vram read-back
    logic [VRAM_AW-1:0]     vram_addr;
    logic                   req_wr;
    logic [PAL_AW-1:0]      pal_idx;
    logic [INTR_BITS-1:0]   intr_mask, intr_status, intr_signal, intr_clear;

    assign reg_sel = reg_num_e'(bus_reg_num_i);
    assign wr_stb  = !bus_cs_n_i && !bus_rd_nwr_i;
    assign rd_stb  = !bus_cs_n_i && bus_rd_nwr_i;
    assign word_wr = wr_stb && bus_bytesel_i;   // odd byte commits the word
    assign wr_word = {hi_byte, bus_data_i};

    assign cpu_addr_o  = vram_addr;             // request always uses current address
    assign cpu_wr_o    = req_wr;
    assign pal_wr_o    = word_wr && (reg_sel == REG_PAL_DATA);
    assign pal_addr_o  = pal_idx;
    assign pal_wdata_o = wr_word[11:0];         // R 11:8, G 7:4, B 3:0

    // status write: odd byte clears, even byte high nibble signals
    always_comb begin
        intr_clear  = '0;
        intr_signal = {{(INTR_BITS-1){1'b0}}, vblank_i};
        if (word_wr && reg_sel == REG_INTR_STATUS) begin
            intr_clear  = bus_data_i[INTR_BITS-1:0];
            intr_signal = intr_signal | hi_byte[7:4];
        end
    end

    // read mux, unreadable registers give zero
    always_comb begin
        case (reg_sel)
            REG_VRAM_ADDR:   rd_word = 16'(vram_addr);
            REG_VRAM_DATA:   rd_word = rb_latch;
            REG_PAL_ADDR:    rd_word = 16'(pal_idx);
            REG_INTR_MASK:   rd_word = 16'(intr_mask);
            REG_INTR_STATUS: rd_word = 16'(intr_status);
            default:         rd_word = 16'h0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_stb && !bus_bytesel_i) begin
            hi_byte <= bus_data_i;
        end
        if (word_wr && reg_sel == REG_VRAM_DATA) begin
            cpu_wdata_o <= wr_word;
        end
        if (cpu_done_i && !req_wr) begin
            rb_latch <= cpu_rdata_i;            // read completed
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_addr   <= '0;
            cpu_req_o   <= 1'b0;
            req_wr      <= 1'b0;
            pal_idx     <= '0;
            intr_mask   <= '0;
            intr_status <= '0;
            bus_intr_o  <= 1'b0;
            bus_data_o  <= 8'h00;
        end else begin
            if (cpu_done_i) begin
                if (req_wr) begin
                    vram_addr <= vram_addr + 1'b1;  // write done, queue read of next
                    req_wr    <= 1'b0;
                end else begin
                    cpu_req_o <= 1'b0;
                end
            end
            if (word_wr) begin
                case (reg_sel)
                    REG_VRAM_ADDR: begin
                        vram_addr <= wr_word[VRAM_AW-1:0];
                        cpu_req_o <= 1'b1;          // prefetch into read-back
                        req_wr    <= 1'b0;
                    end
                    REG_VRAM_DATA: begin
                        cpu_req_o <= 1'b1;
                        req_wr    <= 1'b1;
                    end
                    REG_PAL_ADDR:  pal_idx   <= wr_word[PAL_AW-1:0];
                    REG_PAL_DATA:  pal_idx   <= pal_idx + 1'b1;
                    REG_INTR_MASK: intr_mask <= wr_word[INTR_BITS-1:0];
                    default: ;
                endcase
            end
            if (rd_stb) begin
                bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
                if (bus_bytesel_i && reg_sel == REG_VRAM_DATA) begin
                    vram_addr <= vram_addr + 1'b1;  // step and fetch next word
                    cpu_req_o <= 1'b1;
                    req_wr    <= 1'b0;
                end
            end
            // pulse only for newly pending, enabled lines
            bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);
            intr_status <= (intr_status | intr_signal) & ~intr_clear;
        end
    end

endmodule

`default_nettype wire

/* video_main.sv */
// top level with timing, fetch, color output and cpu register stages
`default_nettype none
`timescale 1ns/1ps

module video_main (
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire logic         bus_cs_n_i,       // register strobe, active low
    input  wire logic         bus_rd_nwr_i,
    input  wire logic [3:0]   bus_reg_num_i,
    input  wire logic         bus_bytesel_i,
    input  wire logic [7:0]   bus_data_i,
    output logic      [7:0]   bus_data_o,
    output logic              bus_intr_o,
    output logic      [3:0]   red_o,
    output logic      [3:0]   green_o,
    output logic      [3:0]   blue_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              dv_de_o
);
    import vdp_pkg::*;

    // stage 1 outputs
    logic [H_CW-1:0]     h_count;
    logic [V_CW-1:0]     v_count;
    logic                tm_de, tm_hsync, tm_vsync, vblank;
    // cpu vram request
    logic                cpu_req, cpu_wr, cpu_done;
    logic [VRAM_AW-1:0]  cpu_addr;
    logic [15:0]         cpu_wdata, cpu_rdata;
    // stage 3 outputs
    logic [PAL_AW-1:0]   color_index;
    logic                pf_de, pf_hsync, pf_vsync;
    // palette write port
    logic                pal_wr;
    logic [PAL_AW-1:0]   pal_addr;
    logic [11:0]         pal_wdata;

    video_timing video_timing_i (
        .clk(clk), .reset_i(reset_i),
        .h_count_o(h_count), .v_count_o(v_count),
        .de_o(tm_de), .hsync_o(tm_hsync), .vsync_o(tm_vsync),
        .vblank_o(vblank)
    );

    pixel_fetch pixel_fetch_i (
        .clk(clk), .reset_i(reset_i),
        .h_count_i(h_count), .v_count_i(v_count),
        .de_i(tm_de), .hsync_i(tm_hsync), .vsync_i(tm_vsync),
        .cpu_req_i(cpu_req), .cpu_wr_i(cpu_wr),
        .cpu_addr_i(cpu_addr), .cpu_wdata_i(cpu_wdata),
        .cpu_done_o(cpu_done), .cpu_rdata_o(cpu_rdata),
        .color_index_o(color_index),
        .de_o(pf_de), .hsync_o(pf_hsync), .vsync_o(pf_vsync)
    );

    color_out color_out_i (
        .clk(clk), .reset_i(reset_i),
        .color_index_i(color_index),
        .de_i(pf_de), .hsync_i(pf_hsync), .vsync_i(pf_vsync),
        .pal_wr_i(pal_wr), .pal_addr_i(pal_addr), .pal_wdata_i(pal_wdata),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    bus_regs bus_regs_i (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
        .cpu_req_o(cpu_req), .cpu_wr_o(cpu_wr),
        .cpu_addr_o(cpu_addr), .cpu_wdata_o(cpu_wdata),
        .cpu_done_i(cpu_done), .cpu_rdata_i(cpu_rdata),
        .pal_wr_o(pal_wr), .pal_addr_o(pal_addr), .pal_wdata_o(pal_wdata),
        .vblank_i(vblank), .bus_intr_o(bus_intr_o)
    );

endmodule

`default_nettype wire

/* video_main_asserts.sv */
// concurrent checks on video_main sync, blanking and interrupt outputs
`default_nettype none
`timescale 1ns/1ps

module video_main_asserts (
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire logic         hsync_i,
    input  wire logic         dv_de_i,
    input  wire logic [3:0]   red_i,
    input  wire logic [3:0]   green_i,
    input  wire logic [3:0]   blue_i,
    input  wire logic         bus_intr_i
);

    // hsync sits in horizontal blank only
    sync_outside_active: assert property (@(posedge clk) disable iff (reset_i)
        !(hsync_i && dv_de_i))
        else $error("hsync_o high while dv_de_o is high");

    // black outside the active area
    rgb_blanked: assert property (@(posedge clk) disable iff (reset_i)
        !dv_de_i |-> ({red_i, green_i, blue_i} == 12'h000))
        else $error("rgb not zero while dv_de_o is low");

    intr_low_after_reset: assert property (@(posedge clk) reset_i |=> !bus_intr_i)
        else $error("bus_intr_o high in the cycle after reset");

endmodule

`default_nettype wire

/* tb_video_main.sv */
// testbench for video_main: bus driver, frame model, lfsr stimulus and watchdog
`default_nettype none
`timescale 1ns/1ps

module tb_video_main;
    import vdp_pkg::*;

    localparam int CLK_NS      = 8;
    localparam int FRAME_CLKS  = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int N_WORDS     = int'(V_VISIBLE) * WORDS_PER_LINE;    // words on screen
    localparam int N_PIXELS    = int'(H_VISIBLE) * int'(V_VISIBLE);
    localparam int GAP_CLKS    = 8;         // above the worst slot wait
    localparam int BUS_CLKS    = 2000;      // vram and palette loading, rounded up
    localparam int WATCHDOG_NS = (6 * FRAME_CLKS + BUS_CLKS) * CLK_NS;

    logic        clk, reset_i;
    logic        bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    logic [3:0]  bus_reg_num_i;
    logic [7:0]  bus_data_i, bus_data_o;
    logic        bus_intr_o, hsync_o, vsync_o, dv_de_o;
    logic [3:0]  red_o, green_o, blue_o;

    logic [16:0] lfsr_q;
    logic [15:0] vram_model [N_WORDS];      // reference copy of the frame
    logic [11:0] pal_model [16];
    int          intr_pulses;               // bus_intr_o high samples

    video_main video_main_i (.*);

    bind video_main video_main_asserts video_main_asserts_i (
        .clk(clk), .reset_i(reset_i), .hsync_i(hsync_o), .dv_de_i(dv_de_o),
        .red_i(red_o), .green_i(green_o), .blue_i(blue_o), .bus_intr_i(bus_intr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("=== FAIL ===");
        $fatal(1);
    end

    // one clock, then drive and sample 1 ns later
    task automatic tick();
        @(posedge clk);
        #1;
        if (bus_intr_o) intr_pulses++;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got == exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // 17 bit fibonacci, taps 17 and 14
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[14:0], lfsr_q[0]};     // one step per bit
        end
    endtask

    task automatic bus_strobe(input logic rd, input reg_num_e r, input logic bsel,
                              input logic [7:0] d);
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = rd;
        bus_reg_num_i = r;
        bus_bytesel_i = bsel;
        bus_data_i    = d;
        tick();
        bus_cs_n_i    = 1'b1;
    endtask

    task automatic bus_write(input reg_num_e r, input logic [15:0] w);
        bus_strobe(1'b0, r, 1'b0, w[15:8]);    // even byte to latch
        bus_strobe(1'b0, r, 1'b1, w[7:0]);     // odd byte commits
    endtask

    task automatic bus_read(input reg_num_e r, output logic [15:0] w);
        bus_strobe(1'b1, r, 1'b0, 8'h00);
        w[15:8] = bus_data_o;                   // valid the clock after the strobe
        bus_strobe(1'b1, r, 1'b1, 8'h00);
        w[7:0]  = bus_data_o;
    endtask

    task automatic wait_vsync_edge(input logic level);
        logic prev;
        do begin
            prev = vsync_o;
            tick();
        end while (!(vsync_o == level && prev != level));
    endtask

    task automatic reset_state();
        logic [15:0] w;
        for (int i = 0; i < 6; i++) begin
            if (i == 5) reset_i = 1'b0;         // last sample right after release
            tick();
            expect_eq("{hsync_o,vsync_o,dv_de_o,bus_intr_o}",
                      16'({hsync_o, vsync_o, dv_de_o, bus_intr_o}), 16'h0000);
            expect_eq("rgb", 16'({red_o, green_o, blue_o}), 16'h0000);
            expect_eq("bus_data_o", 16'(bus_data_o), 16'h0000);
        end
        bus_read(REG_INTR_STATUS, w);
        expect_eq("intr_status", w, 16'h0000);
    endtask

    task automatic vram_roundtrip();
        logic [15:0] w;
        bus_write(REG_VRAM_ADDR, 16'h0000);
        idle(GAP_CLKS);
        for (int i = 0; i < N_WORDS; i++) begin
            rand_bits(16, w);
            vram_model[i] = w;
            bus_write(REG_VRAM_DATA, w);
            idle(GAP_CLKS);                     // write plus next prefetch
        end
        bus_write(REG_VRAM_ADDR, 16'h0000);
        idle(GAP_CLKS);
        for (int i = 0; i < N_WORDS; i++) begin
            bus_read(REG_VRAM_DATA, w);
            expect_eq("vram_data", w, vram_model[i]);
            idle(GAP_CLKS);
        end
    endtask

    task automatic load_palette();
        logic [15:0] w;
        bus_write(REG_PAL_ADDR, 16'h0000);
        for (int i = 0; i < 16; i++) begin
            rand_bits(12, w);
            pal_model[i] = w[11:0];
            bus_write(REG_PAL_DATA, w);         // index steps by itself
        end
    endtask

    task automatic raster_timing();
        int   since_rise, de_cnt, de_lines, vs_cnt, rises;
        logic hs_prev;
        wait_vsync_edge(1'b0);
        since_rise = 0;
        de_cnt     = 0;
        de_lines   = 0;
        vs_cnt     = 0;
        rises      = 0;
        hs_prev    = hsync_o;
        repeat (FRAME_CLKS) begin
            tick();
            since_rise++;
            if (dv_de_o) de_cnt++;
            if (vsync_o) vs_cnt++;
            if (hsync_o && !hs_prev) begin
                if (rises > 0) expect_eq("hsync_o period", 16'(since_rise), 16'(H_TOTAL));
                if (de_cnt != 0) begin          // visible line just ended
                    expect_eq("dv_de_o per line", 16'(de_cnt), 16'(H_VISIBLE));
                    de_lines++;
                end
                rises++;
                since_rise = 0;
                de_cnt     = 0;
            end
            hs_prev = hsync_o;
        end
        expect_eq("dv_de_o lines", 16'(de_lines), 16'(V_VISIBLE));
        expect_eq("vsync_o length", 16'(vs_cnt), 16'(H_TOTAL));
    endtask

    task automatic pixel_stream();
        int          n, x, y;
        logic [15:0] word;
        logic [3:0]  idx;
        wait_vsync_edge(1'b0);
        n = 0;
        repeat (FRAME_CLKS) begin
            tick();
            if (dv_de_o) begin
                x    = n % int'(H_VISIBLE);     // raster order
                y    = n / int'(H_VISIBLE);
                word = vram_model[y * WORDS_PER_LINE + x / 4];
                idx  = 4'(word >> (4 * (3 - x % 4)));   // leftmost pixel on top
                expect_eq("rgb", 16'({red_o, green_o, blue_o}), 16'(pal_model[idx]));
                n++;
            end
        end
        expect_eq("visible pixels", 16'(n), 16'(N_PIXELS));
    endtask

    task automatic interrupts();
        logic [15:0] w;
        // masked vblank only sets status
        wait_vsync_edge(1'b0);
        bus_write(REG_INTR_STATUS, 16'h000F);
        intr_pulses = 0;
        wait_vsync_edge(1'b1);
        expect_eq("bus_intr_o pulses", 16'(intr_pulses), 16'd0);
        bus_read(REG_INTR_STATUS, w);
        expect_eq("intr_status", w, 16'h0001);
        // enabled vblank, one pulse
        bus_write(REG_INTR_STATUS, 16'h000F);
        bus_write(REG_INTR_MASK, 16'h0001);
        intr_pulses = 0;
        wait_vsync_edge(1'b0);
        wait_vsync_edge(1'b1);
        expect_eq("bus_intr_o pulses", 16'(intr_pulses), 16'd1);
        bus_read(REG_INTR_STATUS, w);
        expect_eq("intr_status", w, 16'h0001);
        // software line 2, kept far from vblank
        wait_vsync_edge(1'b0);
        bus_write(REG_INTR_STATUS, 16'h000F);
        bus_write(REG_INTR_MASK, 16'h0004);
        intr_pulses = 0;
        bus_write(REG_INTR_STATUS, 16'h4000);
        idle(2);
        expect_eq("bus_intr_o pulses", 16'(intr_pulses), 16'd1);
        bus_write(REG_INTR_STATUS, 16'h4000);  // still pending, no new pulse
        idle(2);
        expect_eq("bus_intr_o pulses", 16'(intr_pulses), 16'd1);
        bus_read(REG_INTR_STATUS, w);
        expect_eq("intr_status", w, 16'h0004);
        bus_write(REG_INTR_STATUS, 16'h0004);
        bus_read(REG_INTR_STATUS, w);
        expect_eq("intr_status", w, 16'h0000);
    endtask

    initial begin
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        lfsr_q        = 17'd67794;
        intr_pulses   = 0;
        reset_state();
        vram_roundtrip();
        load_palette();
        raster_timing();
        pixel_stream();
        interrupts();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
vdp_pkg.sv
vram.sv
video_timing.sv
pixel_fetch.sv
color_out.sv
bus_regs.sv
video_main.sv
video_main_asserts.sv
tb_video_main.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing --top-module tb_video_main -Mdir obj_dir -f flist.f
	./obj_dir/Vtb_video_main | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
